/* Bender.yml */
package:
  name: raw_acq

dependencies: {}

sources:
  # Design, package first
  - logic/acq_pkg.sv
  - logic/fetch_if.sv
  - logic/raw_capture.sv
  - logic/dram_prefetch.sv
  - logic/acq_regs.sv
  - logic/acq_top.sv

  # Testbench, top module tb_acq_top
  - target: test
    files:
      - testbench/tb_mcb_model.sv
      - testbench/tb_acq_top.sv

/* build.f */
logic/acq_pkg.sv
logic/fetch_if.sv
logic/raw_capture.sv
logic/dram_prefetch.sv
logic/acq_regs.sv
logic/acq_top.sv
testbench/tb_mcb_model.sv
testbench/tb_acq_top.sv

/* logic/acq_pkg.sv */
package acq_pkg;

   // -------------------------------------------------
   // Sizes
   // -------------------------------------------------
   // One antenna sample
   localparam int SAMPLE_BITS  = 24;
   // MCB word address
   localparam int ADDR_BITS    = 21;
   // Samples captured before streaming starts
   localparam int BUF_WORDS    = 16;
   // Buffer address counter width
   localparam int BUF_IDX_BITS = $clog2(BUF_WORDS);
   // Wishbone data bus
   localparam int BUS_BITS     = 8;
   // Bus reads per streamed sample
   localparam int STREAM_BYTES = SAMPLE_BITS / BUS_BITS;

   typedef logic [SAMPLE_BITS-1:0]  sample_t;
   typedef logic [ADDR_BITS-1:0]    mcb_addr_t;
   typedef logic [BUS_BITS-1:0]     bus_word_t;
   typedef logic [BUF_IDX_BITS-1:0] buf_idx_t;

   // -------------------------------------------------
   // Encodings
   // -------------------------------------------------
   // Capture FSM, also shown in system register bits 2..0
   typedef enum logic [2:0] {
      CAP_IDLE  = 3'd0,
      CAP_FILL  = 3'd1,
      CAP_FLUSH = 3'd2,
      CAP_READY = 3'd3
   } cap_state_e;

   // Register map
   typedef enum logic [1:0] {
      AQ_STREAM = 2'd0,
      AQ_RSVD1  = 2'd1,
      AQ_RSVD2  = 2'd2,
      AQ_SYSTEM = 2'd3
   } acq_reg_e;

   // System register flag positions
   localparam int STAT_ENABLE = 7;
   localparam int STAT_ERROR  = 6;
   localparam int STAT_VALID  = 5;

endpackage

/* logic/acq_regs.sv */
module acq_regs (
   input  logic                clock_i,
   input  logic                reset_i,

   input  logic                cyc_i,
   input  logic                stb_i,
   input  logic                we_i,
   input  logic [1:0]          adr_i,
   input  acq_pkg::bus_word_t  dat_i,
   output logic                ack_o,
   output acq_pkg::bus_word_t  dat_o,

   input  logic                io_busy_i,

   input  acq_pkg::sample_t    sample_i,
   input  logic                valid_i,
   input  acq_pkg::cap_state_e state_i,
   input  logic                overrun_i,

   output logic                enable_o,
   output logic                consumed_o
);

   logic               ack_q;
   acq_pkg::bus_word_t dat_q;
   logic               enable_q;
   logic               error_q;
   logic               consumed_q;
   // Byte position within the current sample
   logic [1:0]         index_q;

   logic               access;
   logic               fetch_rd;
   logic               store_wr;
   logic               stream_rd;
   logic               last_byte;
   acq_pkg::acq_reg_e  reg_sel;
   acq_pkg::bus_word_t stream_byte;
   acq_pkg::bus_word_t sys_word;
   acq_pkg::bus_word_t rd_word;

   // -------------------------------------------------
   // Bus decode
   // -------------------------------------------------
   // One access per transfer, ack blocks the repeat
   assign access    = cyc_i && stb_i && !ack_q;
   assign fetch_rd  = access && !we_i;
   assign store_wr  = access && we_i;
   assign reg_sel   = acq_pkg::acq_reg_e'(adr_i);
   assign stream_rd = fetch_rd && (reg_sel == acq_pkg::AQ_STREAM);
   assign last_byte = index_q == 2'(acq_pkg::STREAM_BYTES - 1);

   // MSB first
   always_comb begin
      stream_byte = sample_i[(acq_pkg::STREAM_BYTES - 1 - index_q) * acq_pkg::BUS_BITS
                             +: acq_pkg::BUS_BITS];
   end

   // Status word, bits 4..3 stay zero
   always_comb begin
      sys_word                      = '0;
      sys_word[acq_pkg::STAT_ENABLE] = enable_q;
      sys_word[acq_pkg::STAT_ERROR]  = error_q;
      sys_word[acq_pkg::STAT_VALID]  = valid_i;
      sys_word[2:0]                  = state_i;
   end

   always_comb begin
      case (reg_sel)
         acq_pkg::AQ_STREAM: rd_word = valid_i ? stream_byte : '0;
         acq_pkg::AQ_SYSTEM: rd_word = sys_word;
         acq_pkg::AQ_RSVD1,
         acq_pkg::AQ_RSVD2:  rd_word = '0;
         default:            rd_word = '0;
      endcase
   end

   // -------------------------------------------------
   // Bus response
   // -------------------------------------------------
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // Read data lines up with ack
   always_ff @(posedge clock_i) begin
      if (fetch_rd) begin
         dat_q <= rd_word;
      end
   end

   // Enable only, other system bits read-only
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         enable_q <= 1'b0;
      end else if (store_wr && (reg_sel == acq_pkg::AQ_SYSTEM)) begin
         enable_q <= dat_i[acq_pkg::STAT_ENABLE];
      end
   end

   // -------------------------------------------------
   // Stream byte index
   // -------------------------------------------------
   // Idle I/O port restarts at the first byte
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         index_q <= '0;
      end else if (!io_busy_i) begin
         index_q <= '0;
      end else if (stream_rd && valid_i) begin
         index_q <= last_byte ? 2'd0 : index_q + 2'd1;
      end
   end

   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         consumed_q <= 1'b0;
      end else begin
         consumed_q <= stream_rd && valid_i && last_byte;
      end
   end

   // Sticky, underrun or overrun
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         error_q <= 1'b0;
      end else if ((stream_rd && !valid_i) || overrun_i) begin
         error_q <= 1'b1;
      end
   end

   assign ack_o      = ack_q;
   assign dat_o      = dat_q;
   assign enable_o   = enable_q;
   assign consumed_o = consumed_q;

endmodule

/* logic/acq_top.sv */
module acq_top (
   input  logic                          clock_i,
   input  logic                          reset_i,

   // Antenna samples
   input  logic [acq_pkg::SAMPLE_BITS-1:0] sample_i,
   input  logic                          sample_stb_i,

   // Wishbone classic slave
   input  logic                          cyc_i,
   input  logic                          stb_i,
   input  logic                          we_i,
   input  logic [1:0]                    adr_i,
   input  logic [acq_pkg::BUS_BITS-1:0]  dat_i,
   output logic                          ack_o,
   output logic [acq_pkg::BUS_BITS-1:0]  dat_o,

   input  logic                          io_busy_i,

   // MCB command port
   output logic                          mcb_ce_o,
   output logic                          mcb_wr_o,
   output logic [acq_pkg::ADDR_BITS-1:0] mcb_adr_o,
   output logic [acq_pkg::SAMPLE_BITS-1:0] mcb_dat_o,
   input  logic                          mcb_rdy_i,
   input  logic                          mcb_ack_i,
   input  logic [acq_pkg::SAMPLE_BITS-1:0] mcb_dat_i
);

   logic                enable;
   logic                overrun;
   logic                consumed;
   logic                sample_valid;
   acq_pkg::sample_t    sample;
   acq_pkg::cap_state_e state;

   fetch_if i_fetch ();

   // -------------------------------------------------
   // Capture and read-back
   // -------------------------------------------------
   raw_capture i_capture (
      .clock_i      (clock_i),
      .reset_i      (reset_i),
      .enable_i     (enable),
      .sample_i     (sample_i),
      .sample_stb_i (sample_stb_i),
      .mcb_ce_o     (mcb_ce_o),
      .mcb_wr_o     (mcb_wr_o),
      .mcb_adr_o    (mcb_adr_o),
      .mcb_dat_o    (mcb_dat_o),
      .mcb_rdy_i    (mcb_rdy_i),
      .mcb_ack_i    (mcb_ack_i),
      .mcb_dat_i    (mcb_dat_i),
      .fetch        (i_fetch.capture),
      .state_o      (state),
      .overrun_o    (overrun)
   );

   dram_prefetch i_prefetch (
      .clock_i    (clock_i),
      .reset_i    (reset_i),
      .fetch      (i_fetch.prefetch),
      .consumed_i (consumed),
      .sample_o   (sample),
      .valid_o    (sample_valid)
   );

   // -------------------------------------------------
   // Register slave
   // -------------------------------------------------
   acq_regs i_regs (
      .clock_i    (clock_i),
      .reset_i    (reset_i),
      .cyc_i      (cyc_i),
      .stb_i      (stb_i),
      .we_i       (we_i),
      .adr_i      (adr_i),
      .dat_i      (dat_i),
      .ack_o      (ack_o),
      .dat_o      (dat_o),
      .io_busy_i  (io_busy_i),
      .sample_i   (sample),
      .valid_i    (sample_valid),
      .state_i    (state),
      .overrun_i  (overrun),
      .enable_o   (enable),
      .consumed_o (consumed)
   );

endmodule

/* logic/dram_prefetch.sv */
module dram_prefetch (
   input  logic             clock_i,
   input  logic             reset_i,

   fetch_if.prefetch        fetch,

   input  logic             consumed_i,
   output acq_pkg::sample_t sample_o,
   output logic             valid_o
);

   // Set once the buffer has been seen ready
   logic             started_q;
   // A read is in flight
   logic             pending_q;
   logic             req_q;
   logic             valid_q;
   acq_pkg::sample_t sample_q;

   logic issue;

   // -------------------------------------------------
   // Request generation
   // -------------------------------------------------
   // First word on ready, then one per consumed sample
   assign issue = ((fetch.ready && !started_q) || consumed_i) && !pending_q;

   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         started_q <= 1'b0;
         req_q     <= 1'b0;
      end else begin
         started_q <= started_q || fetch.ready;
         req_q     <= issue;
      end
   end

   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         pending_q <= 1'b0;
      end else if (issue) begin
         pending_q <= 1'b1;
      end else if (fetch.rvalid) begin
         pending_q <= 1'b0;
      end
   end

   // -------------------------------------------------
   // Sample holder
   // -------------------------------------------------
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         valid_q <= 1'b0;
      end else if (fetch.rvalid) begin
         valid_q <= 1'b1;
      end else if (consumed_i) begin
         valid_q <= 1'b0;
      end
   end

   // Held until the next word returns
   always_ff @(posedge clock_i) begin
      if (fetch.rvalid) begin
         sample_q <= fetch.rdata;
      end
   end

   assign fetch.req = req_q;
   assign sample_o  = sample_q;
   assign valid_o   = valid_q;

endmodule

/* logic/fetch_if.sv */
interface fetch_if;

   // Single read request, one-cycle pulse
   logic             req;
   // Read return for the oldest request
   logic             rvalid;
   acq_pkg::sample_t rdata;
   // Buffer filled, reads may start
   logic             ready;

   // Buffer counts as ready once capture has settled
   function automatic logic ready_state(acq_pkg::cap_state_e state);
      return state == acq_pkg::CAP_READY;
   endfunction

   modport capture (
      input  req,
      output rvalid,
      output rdata,
      output ready,
      import ready_state
   );

   modport prefetch (
      output req,
      input  rvalid,
      input  rdata,
      input  ready
   );

endinterface

/* logic/raw_capture.sv */
module raw_capture (
   input  logic                clock_i,
   input  logic                reset_i,
   input  logic                enable_i,

   input  acq_pkg::sample_t    sample_i,
   input  logic                sample_stb_i,

   output logic                mcb_ce_o,
   output logic                mcb_wr_o,
   output acq_pkg::mcb_addr_t  mcb_adr_o,
   output acq_pkg::sample_t    mcb_dat_o,
   input  logic                mcb_rdy_i,
   input  logic                mcb_ack_i,
   input  acq_pkg::sample_t    mcb_dat_i,

   fetch_if.capture            fetch,

   output acq_pkg::cap_state_e state_o,
   output logic                overrun_o
);

   acq_pkg::cap_state_e state_q;
   acq_pkg::buf_idx_t   wr_addr_q;
   acq_pkg::buf_idx_t   rd_addr_q;
   logic                overrun_q;

   logic cmd_accept;
   logic wr_start;
   logic rd_start;
   logic last_write;

   // -------------------------------------------------
   // Command handshake
   // -------------------------------------------------
   assign cmd_accept = mcb_ce_o && mcb_rdy_i;

   // New sample only when no write is pending
   assign wr_start = (state_q == acq_pkg::CAP_FILL) && sample_stb_i && !mcb_ce_o;

   // Prefetch reads only after the buffer is full
   assign rd_start = (state_q == acq_pkg::CAP_READY) && fetch.req && !mcb_ce_o;

   assign last_write = cmd_accept && mcb_wr_o &&
                       (wr_addr_q == acq_pkg::buf_idx_t'(acq_pkg::BUF_WORDS - 1));

   // Control part of the command
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         mcb_ce_o <= 1'b0;
         mcb_wr_o <= 1'b0;
      end else if (cmd_accept) begin
         mcb_ce_o <= 1'b0;
      end else if (wr_start) begin
         mcb_ce_o <= 1'b1;
         mcb_wr_o <= 1'b1;
      end else if (rd_start) begin
         mcb_ce_o <= 1'b1;
         mcb_wr_o <= 1'b0;
      end
   end

   // Address and data held until accepted
   always_ff @(posedge clock_i) begin
      if (wr_start) begin
         mcb_adr_o <= acq_pkg::mcb_addr_t'(wr_addr_q);
         mcb_dat_o <= sample_i;
      end else if (rd_start) begin
         mcb_adr_o <= acq_pkg::mcb_addr_t'(rd_addr_q);
      end
   end

   // -------------------------------------------------
   // Address counters
   // -------------------------------------------------
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         wr_addr_q <= '0;
         rd_addr_q <= '0;
      end else if (cmd_accept) begin
         if (mcb_wr_o) begin
            wr_addr_q <= wr_addr_q + 1'b1;
         end else if (rd_addr_q == acq_pkg::buf_idx_t'(acq_pkg::BUF_WORDS - 1)) begin
            // Read-back wraps around the buffer
            rd_addr_q <= '0;
         end else begin
            rd_addr_q <= rd_addr_q + 1'b1;
         end
      end
   end

   // -------------------------------------------------
   // Capture FSM
   // -------------------------------------------------
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         state_q <= acq_pkg::CAP_IDLE;
      end else begin
         case (state_q)
            acq_pkg::CAP_IDLE: begin
               if (enable_i) begin
                  state_q <= acq_pkg::CAP_FILL;
               end
            end
            acq_pkg::CAP_FILL: begin
               // Last sample written, buffer complete
               if (last_write) begin
                  state_q <= acq_pkg::CAP_FLUSH;
               end
            end
            acq_pkg::CAP_FLUSH: begin
               state_q <= acq_pkg::CAP_READY;
            end
            default: begin
               // Stays ready until reset
               state_q <= acq_pkg::CAP_READY;
            end
         endcase
      end
   end

   // Strobe during a held write is lost
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         overrun_q <= 1'b0;
      end else begin
         overrun_q <= (state_q == acq_pkg::CAP_FILL) && sample_stb_i && mcb_ce_o;
      end
   end

   assign state_o   = state_q;
   assign overrun_o = overrun_q;

   // Read returns straight to the prefetcher
   assign fetch.rvalid = mcb_ack_i && (state_q == acq_pkg::CAP_READY);
   assign fetch.rdata  = mcb_dat_i;
   assign fetch.ready  = fetch.ready_state(state_q);

endmodule

/* testbench/tb_acq_top.sv */
module tb_acq_top;

   logic                clock = 1'b0;
   logic                reset;
   acq_pkg::sample_t    sample;
   logic                sample_stb;
   logic                cyc;
   logic                stb;
   logic                we;
   logic [1:0]          adr;
   acq_pkg::bus_word_t  wdata;
   logic                ack;
   acq_pkg::bus_word_t  rdata;
   logic                io_busy;

   logic                mcb_ce;
   logic                mcb_wr;
   acq_pkg::mcb_addr_t  mcb_adr;
   acq_pkg::sample_t    mcb_wdat;
   logic                mcb_rdy;
   logic                mcb_ack;
   acq_pkg::sample_t    mcb_rdat;

   logic [31:0]         lfsr_q = 32'h8c12;
   logic [5:0]          mem_rand = 6'h00;
   // Reference copy of every captured sample
   acq_pkg::sample_t    captured_q[$];
   // Next sample expected on the stream
   int                  stream_pos = 0;

   always #4 clock = ~clock;

   acq_top i_dut (
      .clock_i      (clock),
      .reset_i      (reset),
      .sample_i     (sample),
      .sample_stb_i (sample_stb),
      .cyc_i        (cyc),
      .stb_i        (stb),
      .we_i         (we),
      .adr_i        (adr),
      .dat_i        (wdata),
      .ack_o        (ack),
      .dat_o        (rdata),
      .io_busy_i    (io_busy),
      .mcb_ce_o     (mcb_ce),
      .mcb_wr_o     (mcb_wr),
      .mcb_adr_o    (mcb_adr),
      .mcb_dat_o    (mcb_wdat),
      .mcb_rdy_i    (mcb_rdy),
      .mcb_ack_i    (mcb_ack),
      .mcb_dat_i    (mcb_rdat)
   );

   tb_mcb_model i_mem (
      .clock_i   (clock),
      .reset_i   (reset),
      .rand_i    (mem_rand),
      .mcb_ce_i  (mcb_ce),
      .mcb_wr_i  (mcb_wr),
      .mcb_adr_i (mcb_adr),
      .mcb_dat_i (mcb_wdat),
      .mcb_rdy_o (mcb_rdy),
      .mcb_ack_o (mcb_ack),
      .mcb_dat_o (mcb_rdat)
   );

   // -------------------------------------------------
   // Random source
   // -------------------------------------------------
   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One step per bit taken
   function automatic logic [31:0] rand_bits(int count);
      logic [31:0] value;
      value = '0;
      for (int b = 0; b < count; b++) begin
         lfsr_q = lfsr_step(lfsr_q);
         value  = {value[30:0], lfsr_q[0]};
      end
      return value;
   endfunction

   // Memory stalls and latency, the only user after time zero
   always @(posedge clock) begin
      mem_rand <= 6'(rand_bits(6));
   end

   // Stream order is most significant byte first
   function automatic acq_pkg::bus_word_t byte_of(acq_pkg::sample_t s, int b);
      return acq_pkg::bus_word_t'(s >> ((acq_pkg::STREAM_BYTES - 1 - b) * acq_pkg::BUS_BITS));
   endfunction

   function automatic acq_pkg::bus_word_t flag_bit(int pos);
      return acq_pkg::bus_word_t'(1) << pos;
   endfunction

   // -------------------------------------------------
   // Failure handling and compares
   // -------------------------------------------------
   task automatic fail_run();
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic timeout_fail(string what);
      $display("Timeout while waiting for %s", what);
      fail_run();
   endtask

   task automatic check_byte(string name, acq_pkg::bus_word_t exp, acq_pkg::bus_word_t act);
      if (act !== exp) begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_sample(string name, acq_pkg::sample_t exp, acq_pkg::sample_t act);
      if (act !== exp) begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_state(string name, acq_pkg::cap_state_e exp,
                              acq_pkg::cap_state_e act);
      if (act !== exp) begin
         $display("FAIL %s expected %s (%0d) actual %s (%0d)", name,
                  exp.name(), exp, act.name(), act);
         fail_run();
      end
   endtask

   // -------------------------------------------------
   // Wishbone classic master
   // -------------------------------------------------
   task automatic write_reg(acq_pkg::acq_reg_e addr, acq_pkg::bus_word_t value);
      int waited;
      waited = 0;
      @(posedge clock);
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= 1'b1;
      adr   <= addr;
      wdata <= value;
      @(posedge clock);
      while (ack !== 1'b1) begin
         if (waited == 16) begin
            timeout_fail("the Wishbone ack of a register write");
         end
         waited++;
         @(posedge clock);
      end
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
   endtask

   // Data sampled at the edge that ends the ack cycle
   task automatic read_reg(acq_pkg::acq_reg_e addr, output acq_pkg::bus_word_t value);
      int waited;
      waited = 0;
      @(posedge clock);
      cyc <= 1'b1;
      stb <= 1'b1;
      we  <= 1'b0;
      adr <= addr;
      @(posedge clock);
      while (ack !== 1'b1) begin
         if (waited == 16) begin
            timeout_fail("the Wishbone ack of a register read");
         end
         waited++;
         @(posedge clock);
      end
      value = rdata;
      cyc <= 1'b0;
      stb <= 1'b0;
   endtask

   task automatic wait_capture_ready(output acq_pkg::bus_word_t sys);
      int polls;
      polls = 0;
      read_reg(acq_pkg::AQ_SYSTEM, sys);
      while (sys[2:0] !== 3'(acq_pkg::CAP_READY)) begin
         if (polls == 50) begin
            timeout_fail("the capture state to reach CAP_READY");
         end
         polls++;
         read_reg(acq_pkg::AQ_SYSTEM, sys);
      end
   endtask

   task automatic wait_sample_valid(output acq_pkg::bus_word_t sys);
      int polls;
      polls = 0;
      read_reg(acq_pkg::AQ_SYSTEM, sys);
      while (sys[acq_pkg::STAT_VALID] !== 1'b1) begin
         if (polls == 50) begin
            timeout_fail("the sample valid bit");
         end
         polls++;
         read_reg(acq_pkg::AQ_SYSTEM, sys);
      end
   endtask

   // Bytes first .. first+count-1 of the expected sample
   task automatic read_stream_bytes(string name, int first, int count, acq_pkg::sample_t exp);
      acq_pkg::bus_word_t got;
      for (int b = first; b < first + count; b++) begin
         read_reg(acq_pkg::AQ_STREAM, got);
         check_byte($sformatf("%s sample %0d byte %0d", name, stream_pos, b),
                    byte_of(exp, b), got);
      end
   endtask

   // -------------------------------------------------
   // Test sequence
   // -------------------------------------------------
   initial begin
      acq_pkg::bus_word_t sys;
      acq_pkg::bus_word_t got;

      reset      <= 1'b1;
      sample     <= '0;
      sample_stb <= 1'b0;
      cyc        <= 1'b0;
      stb        <= 1'b0;
      we         <= 1'b0;
      adr        <= '0;
      wdata      <= '0;
      io_busy    <= 1'b0;

      // Samples drawn before the clock starts
      repeat (acq_pkg::BUF_WORDS) begin
         captured_q.push_back(acq_pkg::sample_t'(rand_bits(acq_pkg::SAMPLE_BITS)));
      end

      repeat (4) @(posedge clock);
      reset <= 1'b0;

      // Idle after reset
      read_reg(acq_pkg::AQ_SYSTEM, sys);
      check_byte("reset system word", '0, sys);
      check_state("reset state", acq_pkg::CAP_IDLE, acq_pkg::cap_state_e'(sys[2:0]));
      read_reg(acq_pkg::AQ_RSVD1, got);
      check_byte("reserved 1", '0, got);
      read_reg(acq_pkg::AQ_RSVD2, got);
      check_byte("reserved 2", '0, got);

      // Enable capture
      write_reg(acq_pkg::AQ_SYSTEM, flag_bit(acq_pkg::STAT_ENABLE));
      read_reg(acq_pkg::AQ_SYSTEM, sys);
      check_byte("enable readback", flag_bit(acq_pkg::STAT_ENABLE),
                 sys & flag_bit(acq_pkg::STAT_ENABLE));
      check_state("fill state", acq_pkg::CAP_FILL, acq_pkg::cap_state_e'(sys[2:0]));

      // One strobe every 8 cycles
      foreach (captured_q[i]) begin
         @(posedge clock);
         sample     <= captured_q[i];
         sample_stb <= 1'b1;
         @(posedge clock);
         sample_stb <= 1'b0;
         repeat (6) @(posedge clock);
      end

      wait_capture_ready(sys);
      check_byte("error after capture", '0, sys & flag_bit(acq_pkg::STAT_ERROR));
      foreach (captured_q[i]) begin
         check_sample($sformatf("DRAM word %0d", i), captured_q[i], i_mem.mem_q[i]);
      end

      // Stream twice around the buffer
      @(posedge clock);
      io_busy <= 1'b1;
      repeat (2 * acq_pkg::BUF_WORDS) begin
         wait_sample_valid(sys);
         read_stream_bytes("stream", 0, acq_pkg::STREAM_BYTES, captured_q[stream_pos]);
         stream_pos = (stream_pos + 1) % acq_pkg::BUF_WORDS;
      end

      // Idle I/O port mid-sample restarts the byte index
      wait_sample_valid(sys);
      check_byte("error after stream", '0, sys & flag_bit(acq_pkg::STAT_ERROR));
      read_stream_bytes("partial", 0, 2, captured_q[stream_pos]);
      @(posedge clock);
      io_busy <= 1'b0;
      @(posedge clock);
      io_busy <= 1'b1;
      read_stream_bytes("restart", 0, acq_pkg::STREAM_BYTES, captured_q[stream_pos]);
      stream_pos = (stream_pos + 1) % acq_pkg::BUF_WORDS;

      // Next fetch cannot be back yet
      read_reg(acq_pkg::AQ_STREAM, got);
      check_byte("underrun data", '0, got);
      read_reg(acq_pkg::AQ_SYSTEM, sys);
      check_byte("underrun error", flag_bit(acq_pkg::STAT_ERROR),
                 sys & flag_bit(acq_pkg::STAT_ERROR));

      $display("TEST PASS");
      $finish;
   end

endmodule

/* testbench/tb_mcb_model.sv */
module tb_mcb_model (
   input  logic               clock_i,
   input  logic               reset_i,
   // Fresh random bits every cycle
   input  logic [5:0]         rand_i,

   input  logic               mcb_ce_i,
   input  logic               mcb_wr_i,
   input  acq_pkg::mcb_addr_t mcb_adr_i,
   input  acq_pkg::sample_t   mcb_dat_i,
   output logic               mcb_rdy_o,
   output logic               mcb_ack_o,
   output acq_pkg::sample_t   mcb_dat_o
);

   // Only the capture buffer is modeled
   acq_pkg::sample_t  mem_q [acq_pkg::BUF_WORDS];
   // Remaining stall cycles
   logic [1:0]        stall_q;
   // Cycles until read data returns
   logic [2:0]        delay_q;
   acq_pkg::sample_t  rd_dat_q;

   logic              accept;
   acq_pkg::buf_idx_t word;

   assign mcb_rdy_o = stall_q == 2'd0;
   assign accept    = mcb_ce_i && mcb_rdy_o;
   assign word      = mcb_adr_i[acq_pkg::BUF_IDX_BITS-1:0];

   // -------------------------------------------------
   // Ready stalls of 1 to 3 cycles
   // -------------------------------------------------
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         stall_q <= 2'd0;
      end else if (stall_q != 2'd0) begin
         stall_q <= stall_q - 2'd1;
      end else if (rand_i[1:0] == 2'd0) begin
         stall_q <= (rand_i[3:2] == 2'd0) ? 2'd1 : rand_i[3:2];
      end
   end

   // Write port
   always_ff @(posedge clock_i) begin
      if (accept && mcb_wr_i) begin
         mem_q[word] <= mcb_dat_i;
      end
   end

   // -------------------------------------------------
   // Reads return 3 to 6 cycles after acceptance
   // -------------------------------------------------
   always_ff @(posedge clock_i) begin
      if (reset_i) begin
         delay_q   <= 3'd0;
         mcb_ack_o <= 1'b0;
      end else begin
         mcb_ack_o <= delay_q == 3'd1;
         if (accept && !mcb_wr_i) begin
            delay_q  <= 3'd2 + 3'(rand_i[5:4]);
            rd_dat_q <= mem_q[word];
         end else if (delay_q != 3'd0) begin
            delay_q <= delay_q - 3'd1;
         end
      end
   end

   assign mcb_dat_o = rd_dat_q;

endmodule
